/* Bender.yml */
package:
  name: rv_exec_slice

sources:
  - rtl/rv_core_pkg.sv
  - rtl/rv_alu.sv
  - rtl/rv_csr_file.sv
  - rtl/rv_regfile.sv
  - rtl/rv_decoder.sv
  - rtl/rv_execute.sv
  - rtl/rv_exec_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_rv_exec_top.sv

/* filelist.f */
rtl/rv_core_pkg.sv
rtl/rv_alu.sv
rtl/rv_csr_file.sv
rtl/rv_regfile.sv
rtl/rv_decoder.sv
rtl/rv_execute.sv
rtl/rv_exec_top.sv
verif/tb_clk_gen.sv
verif/tb_rv_exec_top.sv

/* rtl/rv_alu.sv */
`timescale 1ns/1ps

module rv_alu (
  input  rv_core_pkg::alu_op_t op_i,
  input  logic [31:0]          a_i,
  input  logic [31:0]          b_i,
  input  logic [2:0]           funct3_i,
  output logic [31:0]          result_o,
  output logic                 branch_taken_o
);

  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;

  assign shamt = b_i[4:0];

  // comparisons shared by SLT/SLTU and the branches
  assign eq   = (a_i == b_i);
  assign lt_s = ($signed(a_i) < $signed(b_i));
  assign lt_u = (a_i < b_i);

  always_comb begin
    case (op_i)
      rv_core_pkg::ALU_ADD:  result_o = a_i + b_i;
      rv_core_pkg::ALU_SUB:  result_o = a_i - b_i;
      rv_core_pkg::ALU_SLL:  result_o = a_i << shamt;
      rv_core_pkg::ALU_SRL:  result_o = a_i >> shamt;
      rv_core_pkg::ALU_SRA:  result_o = 32'($signed(a_i) >>> shamt);
      rv_core_pkg::ALU_AND:  result_o = a_i & b_i;
      rv_core_pkg::ALU_OR:   result_o = a_i | b_i;
      rv_core_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      rv_core_pkg::ALU_SLT:  result_o = {31'd0, lt_s};
      rv_core_pkg::ALU_SLTU: result_o = {31'd0, lt_u};
      default:               result_o = a_i + b_i;
    endcase
  end

  // BEQ BNE BLT BGE BLTU BGEU
  always_comb begin
    case (funct3_i)
      3'b000:  branch_taken_o = eq;
      3'b001:  branch_taken_o = !eq;
      3'b100:  branch_taken_o = lt_s;
      3'b101:  branch_taken_o = !lt_s;
      3'b110:  branch_taken_o = lt_u;
      3'b111:  branch_taken_o = !lt_u;
      default: branch_taken_o = 1'b0;
    endcase
  end

endmodule

/* rtl/rv_core_pkg.sv */
package rv_core_pkg;

  // major opcodes, encoded as instr[6:0]
  typedef enum logic [6:0] {
    LUI     = 7'b0110111,
    AUIPC   = 7'b0010111,
    JAL     = 7'b1101111,
    JALR    = 7'b1100111,
    BRANCH  = 7'b1100011,
    LOAD    = 7'b0000011,
    STORE   = 7'b0100011,
    IMMED   = 7'b0010011,
    REGREG  = 7'b0110011,
    SYSTEM  = 7'b1110011,
    MISCMEM = 7'b0001111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,
    ALU_SLTU
  } alu_op_t;

  // source of the rd write value
  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_IMM,
    WB_CSR
  } wb_sel_t;

  // same order as funct3[1:0] of the CSR instructions
  typedef enum logic [1:0] {
    CSR_NONE,
    CSR_SWAP,
    CSR_SET,
    CSR_CLEAR
  } csr_op_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    alu_op_t     alu_op;
    logic        alu_a_pc;
    logic        alu_b_imm;
    wb_sel_t     wb_sel;
    logic        wen;
    logic        branch;
    logic [2:0]  funct3;
    logic        jump;
    logic        jalr;
    csr_op_t     csr_op;
    logic        csr_imm;
    logic [11:0] csr_addr;
    logic [4:0]  zimm;
    logic        mret;
    logic        ecall;
    logic        ebreak;
    logic        illegal;
    logic        halt;
  } ctrl_t;

  typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        wen;
    logic        redirect;
    logic [31:0] target;
    logic        ecall;
    logic        ebreak;
    logic        illegal;
    logic        halt;
  } retire_t;

  // machine CSRs that exist
  localparam logic [11:0] csr_mtvec    = 12'h305;
  localparam logic [11:0] csr_mscratch = 12'h340;
  localparam logic [11:0] csr_mepc     = 12'h341;

endpackage

/* rtl/rv_csr_file.sv */
`timescale 1ns/1ps

module rv_csr_file (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 en_i,
  input  rv_core_pkg::csr_op_t op_i,
  input  logic [11:0]          addr_i,
  input  logic [31:0]          operand_i,
  output logic [31:0]          rdata_o,
  output logic [31:0]          mepc_o
);

  logic [31:0] mtvec_q;
  logic [31:0] mscratch_q;
  logic [31:0] mepc_q;
  logic [31:0] wdata;

  // old value, zero for addresses not implemented
  always_comb begin
    case (addr_i)
      rv_core_pkg::csr_mtvec:    rdata_o = mtvec_q;
      rv_core_pkg::csr_mscratch: rdata_o = mscratch_q;
      rv_core_pkg::csr_mepc:     rdata_o = mepc_q;
      default:                   rdata_o = 32'd0;
    endcase
  end

  always_comb begin
    case (op_i)
      rv_core_pkg::CSR_SWAP:  wdata = operand_i;
      rv_core_pkg::CSR_SET:   wdata = rdata_o | operand_i;
      rv_core_pkg::CSR_CLEAR: wdata = rdata_o & ~operand_i;
      default:                wdata = rdata_o;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else if (en_i && op_i != rv_core_pkg::CSR_NONE) begin
      case (addr_i)
        rv_core_pkg::csr_mtvec:    mtvec_q    <= wdata;
        rv_core_pkg::csr_mscratch: mscratch_q <= wdata;
        rv_core_pkg::csr_mepc:     mepc_q     <= wdata;
        default: ;
      endcase
    end
  end

  assign mepc_o = mepc_q;

endmodule

/* rtl/rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder #(
  parameter bit halt_on_self_loop = 1'b0
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               issue_valid_i,
  input  logic [31:0]        issue_instr_i,
  input  logic [31:0]        issue_pc_i,
  output logic               dec_valid_o,
  output rv_core_pkg::ctrl_t dec_ctrl_o
);

  rv_core_pkg::opcode_t opcode;
  rv_core_pkg::alu_op_t alu_sel;
  rv_core_pkg::ctrl_t   ctrl_d;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [11:0]          funct12;
  logic [31:0]          imm_i;
  logic [31:0]          imm_s;
  logic [31:0]          imm_b;
  logic [31:0]          imm_u;
  logic [31:0]          imm_j;
  logic                 base_wen;

  // unknown encodings simply match no case item below
  assign opcode  = rv_core_pkg::opcode_t'(issue_instr_i[6:0]);
  assign funct3  = issue_instr_i[14:12];
  assign funct7  = issue_instr_i[31:25];
  assign funct12 = issue_instr_i[31:20];

  // immediate formats, sign taken from bit 31
  assign imm_i = {{20{issue_instr_i[31]}}, issue_instr_i[31:20]};
  assign imm_s = {{20{issue_instr_i[31]}}, issue_instr_i[31:25], issue_instr_i[11:7]};
  assign imm_b = {{19{issue_instr_i[31]}}, issue_instr_i[31], issue_instr_i[7],
                  issue_instr_i[30:25], issue_instr_i[11:8], 1'b0};
  assign imm_u = {issue_instr_i[31:12], 12'b0};
  assign imm_j = {{11{issue_instr_i[31]}}, issue_instr_i[31], issue_instr_i[19:12],
                  issue_instr_i[20], issue_instr_i[30:21], 1'b0};

  // bit 30 picks SUB (register form only) and SRA
  always_comb begin
    case (funct3)
      3'b000: begin
        if (opcode == rv_core_pkg::REGREG && issue_instr_i[30]) begin
          alu_sel = rv_core_pkg::ALU_SUB;
        end else begin
          alu_sel = rv_core_pkg::ALU_ADD;
        end
      end
      3'b001: alu_sel = rv_core_pkg::ALU_SLL;
      3'b010: alu_sel = rv_core_pkg::ALU_SLT;
      3'b011: alu_sel = rv_core_pkg::ALU_SLTU;
      3'b100: alu_sel = rv_core_pkg::ALU_XOR;
      3'b101: begin
        alu_sel = issue_instr_i[30] ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
      end
      3'b110: alu_sel = rv_core_pkg::ALU_OR;
      default: alu_sel = rv_core_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    ctrl_d          = '0;
    ctrl_d.pc       = issue_pc_i;
    ctrl_d.rs1      = issue_instr_i[19:15];
    ctrl_d.rs2      = issue_instr_i[24:20];
    ctrl_d.rd       = issue_instr_i[11:7];
    ctrl_d.funct3   = funct3;
    ctrl_d.alu_op   = rv_core_pkg::ALU_ADD;
    ctrl_d.wb_sel   = rv_core_pkg::WB_ALU;
    ctrl_d.csr_op   = rv_core_pkg::CSR_NONE;
    ctrl_d.csr_addr = funct12;
    ctrl_d.zimm     = issue_instr_i[19:15];
    base_wen        = 1'b0;

    case (opcode)
      rv_core_pkg::LUI: begin
        ctrl_d.imm    = imm_u;
        ctrl_d.wb_sel = rv_core_pkg::WB_IMM;
        base_wen      = 1'b1;
      end
      rv_core_pkg::AUIPC: begin
        ctrl_d.imm       = imm_u;
        ctrl_d.alu_a_pc  = 1'b1;
        ctrl_d.alu_b_imm = 1'b1;
        base_wen         = 1'b1;
      end
      rv_core_pkg::JAL: begin
        ctrl_d.imm    = imm_j;
        ctrl_d.jump   = 1'b1;
        ctrl_d.wb_sel = rv_core_pkg::WB_PC4;
        base_wen      = 1'b1;
      end
      rv_core_pkg::JALR: begin
        // target comes out of the ALU as rs1 + imm
        ctrl_d.imm       = imm_i;
        ctrl_d.alu_b_imm = 1'b1;
        ctrl_d.jump      = 1'b1;
        ctrl_d.jalr      = 1'b1;
        ctrl_d.wb_sel    = rv_core_pkg::WB_PC4;
        base_wen         = 1'b1;
      end
      rv_core_pkg::BRANCH: begin
        ctrl_d.imm    = imm_b;
        ctrl_d.branch = 1'b1;
      end
      rv_core_pkg::IMMED: begin
        ctrl_d.imm       = imm_i;
        ctrl_d.alu_b_imm = 1'b1;
        ctrl_d.alu_op    = alu_sel;
        base_wen         = 1'b1;
      end
      rv_core_pkg::REGREG: begin
        // funct7[0] marks the M extension
        ctrl_d.alu_op  = alu_sel;
        ctrl_d.illegal = funct7[0];
        base_wen       = 1'b1;
      end
      rv_core_pkg::SYSTEM: begin
        if (funct3 == 3'b000) begin
          case (funct12)
            12'h000: ctrl_d.ecall   = 1'b1;
            12'h001: ctrl_d.ebreak  = 1'b1;
            12'h302: ctrl_d.mret    = 1'b1;
            default: ctrl_d.illegal = 1'b1;
          endcase
        end else if (funct3 != 3'b100) begin
          ctrl_d.csr_op  = rv_core_pkg::csr_op_t'(funct3[1:0]);
          ctrl_d.csr_imm = funct3[2];
          ctrl_d.wb_sel  = rv_core_pkg::WB_CSR;
          base_wen       = 1'b1;
        end
      end
      rv_core_pkg::STORE: begin
        // no memory port, decoded for the immediate only
        ctrl_d.imm     = imm_s;
        ctrl_d.illegal = 1'b1;
      end
      default: begin
        ctrl_d.illegal = 1'b1;
      end
    endcase

    ctrl_d.wen  = base_wen && !ctrl_d.illegal;
    ctrl_d.halt = halt_on_self_loop && (issue_instr_i == 32'h0000006f);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= issue_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_valid_i) begin
      dec_ctrl_o <= ctrl_d;
    end
  end

  // an issued instruction and its pc must be fully known
  a_issue_known: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_valid_i |-> !$isunknown({issue_instr_i, issue_pc_i}));

endmodule

/* rtl/rv_exec_top.sv */
`timescale 1ns/1ps

module rv_exec_top #(
  parameter bit halt_on_self_loop = 1'b0
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 issue_valid_i,
  input  logic [31:0]          issue_instr_i,
  input  logic [31:0]          issue_pc_i,
  output logic                 retire_valid_o,
  output rv_core_pkg::retire_t retire_o
);

  logic               dec_valid;
  rv_core_pkg::ctrl_t dec_ctrl;
  logic [31:0]        rs1_data;
  logic [31:0]        rs2_data;
  logic               rf_we;
  logic [4:0]         rf_waddr;
  logic [31:0]        rf_wdata;

  // decode stage, one cycle
  rv_decoder #(
    .halt_on_self_loop (halt_on_self_loop)
  ) decoder_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .issue_instr_i (issue_instr_i),
    .issue_pc_i    (issue_pc_i),
    .dec_valid_o   (dec_valid),
    .dec_ctrl_o    (dec_ctrl)
  );

  // read in execute, written back at the retire edge
  rv_regfile regfile_i (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .rs1_i      (dec_ctrl.rs1),
    .rs2_i      (dec_ctrl.rs2),
    .we_i       (rf_we),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data)
  );

  rv_execute execute_i (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .dec_valid_i    (dec_valid),
    .dec_ctrl_i     (dec_ctrl),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .rf_we_o        (rf_we),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

endmodule

/* rtl/rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 dec_valid_i,
  input  rv_core_pkg::ctrl_t   dec_ctrl_i,
  input  logic [31:0]          rs1_data_i,
  input  logic [31:0]          rs2_data_i,
  output logic                 rf_we_o,
  output logic [4:0]           rf_waddr_o,
  output logic [31:0]          rf_wdata_o,
  output logic                 retire_valid_o,
  output rv_core_pkg::retire_t retire_o
);

  logic [31:0]          alu_a;
  logic [31:0]          alu_b;
  logic [31:0]          alu_result;
  logic                 branch_taken;
  logic [31:0]          csr_operand;
  logic [31:0]          csr_rdata;
  logic [31:0]          mepc;
  logic [31:0]          wdata;
  logic [31:0]          pc_imm;
  logic [31:0]          target;
  logic                 redirect;
  rv_core_pkg::retire_t rec;

  assign alu_a = dec_ctrl_i.alu_a_pc ? dec_ctrl_i.pc : rs1_data_i;
  assign alu_b = dec_ctrl_i.alu_b_imm ? dec_ctrl_i.imm : rs2_data_i;

  rv_alu alu_i (
    .op_i           (dec_ctrl_i.alu_op),
    .a_i            (alu_a),
    .b_i            (alu_b),
    .funct3_i       (dec_ctrl_i.funct3),
    .result_o       (alu_result),
    .branch_taken_o (branch_taken)
  );

  // immediate forms use the zero-extended rs1 field
  assign csr_operand = dec_ctrl_i.csr_imm ? {27'd0, dec_ctrl_i.zimm} : rs1_data_i;

  rv_csr_file csr_i (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .en_i      (dec_valid_i),
    .op_i      (dec_ctrl_i.csr_op),
    .addr_i    (dec_ctrl_i.csr_addr),
    .operand_i (csr_operand),
    .rdata_o   (csr_rdata),
    .mepc_o    (mepc)
  );

  always_comb begin
    case (dec_ctrl_i.wb_sel)
      rv_core_pkg::WB_PC4: wdata = dec_ctrl_i.pc + 32'd4;
      rv_core_pkg::WB_IMM: wdata = dec_ctrl_i.imm;
      rv_core_pkg::WB_CSR: wdata = csr_rdata;
      default:             wdata = alu_result;
    endcase
  end

  // branch and JAL share this adder, JALR takes the ALU sum
  assign pc_imm = dec_ctrl_i.pc + dec_ctrl_i.imm;

  always_comb begin
    if (dec_ctrl_i.mret) begin
      target = mepc;
    end else if (dec_ctrl_i.jalr) begin
      target = {alu_result[31:1], 1'b0};
    end else begin
      target = pc_imm;
    end
  end

  assign redirect = dec_ctrl_i.jump || dec_ctrl_i.mret ||
                    (dec_ctrl_i.branch && branch_taken);

  // write lands on the same edge as the retire record
  assign rf_we_o    = dec_valid_i && dec_ctrl_i.wen && (dec_ctrl_i.rd != 5'd0);
  assign rf_waddr_o = dec_ctrl_i.rd;
  assign rf_wdata_o = wdata;

  always_comb begin
    rec          = '0;
    rec.pc       = dec_ctrl_i.pc;
    rec.rd       = dec_ctrl_i.rd;
    rec.wdata    = wdata;
    rec.wen      = dec_ctrl_i.wen && (dec_ctrl_i.rd != 5'd0);
    rec.redirect = redirect;
    rec.target   = target;
    rec.ecall    = dec_ctrl_i.ecall;
    rec.ebreak   = dec_ctrl_i.ebreak;
    rec.illegal  = dec_ctrl_i.illegal;
    rec.halt     = dec_ctrl_i.halt;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      retire_valid_o <= 1'b0;
    end else begin
      retire_valid_o <= dec_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (dec_valid_i) begin
      retire_o <= rec;
    end
  end

  // traps and illegal ops retire with no write and no redirect
  a_no_side_effects: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    retire_valid_o && (retire_o.illegal || retire_o.ecall || retire_o.ebreak)
    |-> !retire_o.wen && !retire_o.redirect);

endmodule

/* rtl/rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic [4:0]  rs1_i,
  input  logic [4:0]  rs2_i,
  input  logic        we_i,
  input  logic [4:0]  waddr_i,
  input  logic [31:0] wdata_i,
  output logic [31:0] rs1_data_o,
  output logic [31:0] rs2_data_o
);

  logic [31:0] regs [32];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // x0 reads as zero
  assign rs1_data_o = (rs1_i == 5'd0) ? 32'd0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == 5'd0) ? 32'd0 : regs[rs2_i];

  // execute stage filters rd == 0 before asking for a write
  a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    we_i |-> waddr_i != 5'd0);

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 10,
  parameter int reset_cycles = 8
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like the stimulus
  initial begin
    rst_n_o = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;
  end

endmodule

/* verif/tb_rv_exec_top.sv */
`timescale 1ns/1ps

module tb_rv_exec_top;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] pc;
    logic [3:0]  gap;
    logic [4:0]  rd;
    logic [31:0] wdata;
    logic        wen;
    logic        redirect;
    logic [31:0] target;
    logic [3:0]  flags;
  } entry_t;

  // flag bits are {ecall, ebreak, illegal, halt}
  localparam int fl_ecall   = 8;
  localparam int fl_ebreak  = 4;
  localparam int fl_illegal = 2;
  localparam int fl_halt    = 1;

  logic                 clk;
  logic                 rst_n;
  logic                 issue_valid_i;
  logic [31:0]          issue_instr_i;
  logic [31:0]          issue_pc_i;
  logic                 retire_valid_o;
  rv_core_pkg::retire_t retire_o;

  entry_t tbl[$];
  entry_t exp_q[$];
  int     issue_cyc_q[$];
  entry_t exp_e;
  int     exp_cyc;
  int     cyc = 0;
  int     n_retired = 0;
  int     max_gap = 0;
  bit     tbl_ready = 1'b0;

  tb_clk_gen #(
    .period_ns    (10),
    .reset_cycles (8)
  ) clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  rv_exec_top #(
    .halt_on_self_loop (1'b1)
  ) dut_i (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .issue_valid_i  (issue_valid_i),
    .issue_instr_i  (issue_instr_i),
    .issue_pc_i     (issue_pc_i),
    .retire_valid_o (retire_valid_o),
    .retire_o       (retire_o)
  );

  // RV32I encoders
  function automatic logic [31:0] itype(input int imm, input int rs1, input int f3,
                                        input int rd);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13};
  endfunction

  function automatic logic [31:0] rtype(input int f7, input int rs2, input int rs1,
                                        input int f3, input int rd);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
  endfunction

  function automatic logic [31:0] utype(input int imm, input int rd, input int op);
    return {imm[19:0], rd[4:0], op[6:0]};
  endfunction

  function automatic logic [31:0] jal_instr(input int imm, input int rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
  endfunction

  function automatic logic [31:0] jalr_instr(input int imm, input int rs1, input int rd);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'h67};
  endfunction

  function automatic logic [31:0] btype(input int imm, input int rs2, input int rs1,
                                        input int f3);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
  endfunction

  // src is rs1 or zimm
  function automatic logic [31:0] csr_instr(input int addr, input int src, input int f3,
                                            input int rd);
    return {addr[11:0], src[4:0], f3[2:0], rd[4:0], 7'h73};
  endfunction

  task automatic add_row(input int instr, input int pc, input int gap, input int rd,
                         input int wdata, input int wen, input int redirect,
                         input int target, input int flags);
    entry_t e;
    e.instr    = instr;
    e.pc       = pc;
    e.gap      = gap[3:0];
    e.rd       = rd[4:0];
    e.wdata    = wdata;
    e.wen      = wen[0];
    e.redirect = redirect[0];
    e.target   = target;
    e.flags    = flags[3:0];
    tbl.push_back(e);
    if (gap > max_gap) begin
      max_gap = gap;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("MISMATCH %s: expected 0x%08h, got 0x%08h", name, expected, actual);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic build_table();
    // ALU ops, registers built up from x0
    add_row(itype(5, 0, 0, 1), 'h100, 0, 1, 'h5, 1, 0, 0, 0);
    add_row(itype(-3, 0, 0, 2), 'h104, 1, 2, 'hfffffffd, 1, 0, 0, 0);
    add_row(itype(1, 2, 2, 3), 'h108, 0, 3, 'h1, 1, 0, 0, 0);
    add_row(itype('hf0, 1, 4, 4), 'h10c, 2, 4, 'hf5, 1, 0, 0, 0);
    add_row(itype(4, 1, 1, 5), 'h110, 0, 5, 'h50, 1, 0, 0, 0);
    add_row(itype('h401, 2, 5, 6), 'h114, 0, 6, 'hfffffffe, 1, 0, 0, 0);
    add_row(itype(28, 2, 5, 7), 'h118, 0, 7, 'hf, 1, 0, 0, 0);
    add_row(rtype(0, 4, 1, 0, 8), 'h11c, 0, 8, 'hfa, 1, 0, 0, 0);
    add_row(rtype('h20, 4, 1, 0, 9), 'h120, 0, 9, 'hffffff10, 1, 0, 0, 0);
    add_row(rtype(0, 2, 1, 3, 10), 'h124, 0, 10, 'h1, 1, 0, 0, 0);
    // back to back on the previous rd, then x0 stays zero
    add_row(itype('h123, 0, 0, 11), 'h128, 0, 11, 'h123, 1, 0, 0, 0);
    add_row(itype(1, 11, 0, 12), 'h12c, 0, 12, 'h124, 1, 0, 0, 0);
    add_row(rtype(0, 12, 12, 0, 13), 'h130, 0, 13, 'h248, 1, 0, 0, 0);
    add_row(itype(7, 1, 0, 0), 'h134, 0, 0, 0, 0, 0, 0, 0);
    add_row(rtype(0, 1, 0, 0, 14), 'h138, 0, 14, 'h5, 1, 0, 0, 0);
    // upper immediates and jumps
    add_row(utype('h12345, 15, 'h37), 'h13c, 3, 15, 'h12345000, 1, 0, 0, 0);
    add_row(utype('h1, 16, 'h17), 'h140, 0, 16, 'h1140, 1, 0, 0, 0);
    add_row(jal_instr(16, 17), 'h144, 0, 17, 'h148, 1, 1, 'h154, 0);
    add_row(jalr_instr('h20, 1, 18), 'h154, 0, 18, 'h158, 1, 1, 'h24, 0);
    add_row(jal_instr(-16, 0), 'h200, 0, 0, 0, 0, 1, 'h1f0, 0);
    // branches, taken and not taken
    add_row(btype(8, 14, 1, 0), 'h300, 0, 0, 0, 0, 1, 'h308, 0);
    add_row(btype(8, 2, 1, 0), 'h304, 0, 0, 0, 0, 0, 0, 0);
    add_row(btype(-32, 1, 2, 4), 'h308, 0, 0, 0, 0, 1, 'h2e8, 0);
    add_row(btype(12, 2, 1, 7), 'h30c, 0, 0, 0, 0, 0, 0, 0);
    add_row(btype(12, 1, 2, 7), 'h310, 0, 0, 0, 0, 1, 'h31c, 0);
    add_row(btype(-32, 2, 1, 4), 'h314, 0, 0, 0, 0, 0, 0, 0);
    // mscratch swap, set, clear-immediate, read back
    add_row(csr_instr('h340, 4, 1, 19), 'h400, 1, 19, 'h0, 1, 0, 0, 0);
    add_row(csr_instr('h340, 11, 2, 20), 'h404, 0, 20, 'hf5, 1, 0, 0, 0);
    add_row(csr_instr('h340, 7, 7, 21), 'h408, 0, 21, 'h1f7, 1, 0, 0, 0);
    add_row(csr_instr('h340, 0, 2, 22), 'h40c, 0, 22, 'h1f0, 1, 0, 0, 0);
    // mepc then MRET
    add_row(csr_instr('h341, 16, 1, 0), 'h410, 0, 0, 0, 0, 0, 0, 0);
    add_row('h30200073, 'h414, 0, 0, 0, 0, 1, 'h1140, 0);
    // unknown CSR ignores the write and reads zero
    add_row(csr_instr('h7c0, 1, 1, 23), 'h418, 0, 23, 'h0, 1, 0, 0, 0);
    add_row(csr_instr('h7c0, 0, 2, 24), 'h41c, 0, 24, 'h0, 1, 0, 0, 0);
    // LOAD, MUL, unknown opcode, ECALL, EBREAK, self jump
    add_row('h0000ad03, 'h480, 0, 0, 0, 0, 0, 0, fl_illegal);
    add_row(rtype(1, 1, 1, 0, 27), 'h484, 0, 0, 0, 0, 0, 0, fl_illegal);
    add_row('h00000d7f, 'h488, 0, 0, 0, 0, 0, 0, fl_illegal);
    add_row('h00000073, 'h48c, 0, 0, 0, 0, 0, 0, fl_ecall);
    add_row('h00100073, 'h490, 0, 0, 0, 0, 0, 0, fl_ebreak);
    add_row('h0000006f, 'h500, 0, 0, 0, 0, 1, 'h500, fl_halt);
    // x26 and x27 must still be zero
    add_row(rtype(0, 27, 26, 0, 28), 'h504, 0, 28, 'h0, 1, 0, 0, 0);
  endtask

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // retire checker, sampled away from the active edge
  always @(negedge clk) begin
    if (rst_n && retire_valid_o) begin
      if (exp_q.size() == 0) begin
        $display("retire strobe seen with no instruction outstanding");
        $display("Testbench failed");
        $fatal(1);
      end else begin
        exp_e   = exp_q.pop_front();
        exp_cyc = issue_cyc_q.pop_front();
        check_value("retire_cycle", cyc, exp_cyc + 2);
        check_value("retire_o.pc", retire_o.pc, exp_e.pc);
        check_value("retire_o.wen", {31'd0, retire_o.wen}, {31'd0, exp_e.wen});
        if (exp_e.wen) begin
          check_value("retire_o.rd", {27'd0, retire_o.rd}, {27'd0, exp_e.rd});
          check_value("retire_o.wdata", retire_o.wdata, exp_e.wdata);
        end
        check_value("retire_o.redirect", {31'd0, retire_o.redirect},
                    {31'd0, exp_e.redirect});
        if (exp_e.redirect) begin
          check_value("retire_o.target", retire_o.target, exp_e.target);
        end
        check_value("retire_o.flags",
                    {28'd0, retire_o.ecall, retire_o.ebreak, retire_o.illegal, retire_o.halt},
                    {28'd0, exp_e.flags});
        n_retired++;
      end
    end
  end

  // watchdog sized from the table
  initial begin
    wait (tbl_ready);
    #(tbl.size() * (max_gap + 4) * 10 + 8 * 10);
    $display("timeout: not every issued instruction retired in time");
    $display("Testbench failed");
    $fatal(1);
  end

  initial begin
    issue_valid_i = 1'b0;
    issue_instr_i = '0;
    issue_pc_i    = '0;
    build_table();
    tbl_ready = 1'b1;
    wait (rst_n);
    for (int i = 0; i < tbl.size(); i++) begin
      repeat (tbl[i].gap) begin
        @(posedge clk);
        #1;
        issue_valid_i = 1'b0;
      end
      @(posedge clk);
      #1;
      issue_valid_i = 1'b1;
      issue_instr_i = tbl[i].instr;
      issue_pc_i    = tbl[i].pc;
      exp_q.push_back(tbl[i]);
      issue_cyc_q.push_back(cyc);
    end
    @(posedge clk);
    #1;
    issue_valid_i = 1'b0;
    while (n_retired < tbl.size()) begin
      @(negedge clk);
    end
    // one more cycle to catch a stray retire
    @(negedge clk);
    if (n_retired == tbl.size() && exp_q.size() == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
